// File: common/strand_pkg.sv
/*
 * Shared definitions for the strand control subsystem
 * Strand and core constants, control register indices,
 * and the access, fault, rollback and issue records
 */
`default_nettype none

package strand_pkg;

	// Four hardware strands in the barrel
	localparam int NUM_STRANDS = 4;
	localparam int STRAND_BITS = 2;

	// Core number placed above the strand number in the strand ID register
	localparam logic [31 - STRAND_BITS:0] CORE_ID = '0;

	// Strand number
	typedef logic [STRAND_BITS - 1:0] strand_t;

	// Control register indices
	typedef enum logic [4:0]
	{
		CR_STRAND_ID = 5'd0,
		CR_EXCEPTION_HANDLER = 5'd1,
		CR_FAULT_ADDRESS = 5'd2,
		CR_HALT_STRAND = 5'd29,
		CR_STRAND_ENABLE = 5'd30,
		CR_HALT = 5'd31
	} cr_index_t;

	// One control register access from the execute stage
	typedef struct packed
	{
		logic read_en;
		logic write_en;
		// Strand that makes the access
		strand_t strand;
		cr_index_t index;
		logic [31:0] write_value;
	} cr_access_t;

	// Single-cycle fault pulse from writeback
	typedef struct packed
	{
		logic valid;
		strand_t strand;
		// PC of the faulting instruction
		logic [31:0] pc;
	} fault_t;

	// Branch rollback from writeback
	typedef struct packed
	{
		logic valid;
		strand_t strand;
		// Address to restart from
		logic [31:0] target;
	} rollback_t;

	// Strand chosen to issue this cycle
	typedef struct packed
	{
		logic valid;
		strand_t strand;
		logic [31:0] pc;
	} issue_t;

endpackage

`default_nettype wire

// File: source/control_registers.sv
/*
 * Control register file
 * Read mux, register writes, strand halts and saved fault PCs
 */
`timescale 1ns/100ps
`default_nettype none

module control_registers
	import strand_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Access from execute, fault from writeback
	input wire cr_access_t access,
	input wire fault_t fault,

	output logic [31:0] read_value,
	output logic [NUM_STRANDS - 1:0] strand_enable,
	output logic [31:0] exception_handler
);

	// One saved fault PC per strand
	logic [31:0] saved_fault_pc [NUM_STRANDS];

	// Combinational read path
	// Zero when not reading or when the index maps to nothing
	always_comb
	begin
		read_value = '0;
		if (access.read_en)
		begin
			case (access.index)
				CR_STRAND_ID:
				begin
					// Core number above the strand number
					read_value = {CORE_ID, access.strand};
				end

				CR_EXCEPTION_HANDLER:
				begin
					read_value = exception_handler;
				end

				CR_FAULT_ADDRESS:
				begin
					// Each strand sees its own fault PC
					read_value = saved_fault_pc[access.strand];
				end

				CR_STRAND_ENABLE:
				begin
					read_value = {{(32 - NUM_STRANDS){1'b0}}, strand_enable};
				end

				default:
				begin
					read_value = '0;
				end
			endcase
		end
	end

	// Register updates
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			// Only strand 0 runs out of reset
			strand_enable <= NUM_STRANDS'(1);
			exception_handler <= '0;
			for (int i = 0; i < NUM_STRANDS; i++)
				saved_fault_pc[i] <= '0;
		end
		else
		begin
			if (access.write_en)
			begin
				case (access.index)
					CR_EXCEPTION_HANDLER:
						exception_handler <= access.write_value;

					// Mask comes from the low bits
					CR_STRAND_ENABLE:
						strand_enable <= access.write_value[NUM_STRANDS - 1:0];

					// Writing strand stops itself
					CR_HALT_STRAND:
						strand_enable <= strand_enable & ~(NUM_STRANDS'(1) << access.strand);

					// Stop every strand
					CR_HALT:
						strand_enable <= '0;

					default:
					begin
					end
				endcase
			end

			// Capture the PC of a faulting instruction
			if (fault.valid)
				saved_fault_pc[fault.strand] <= fault.pc;
		end
	end

endmodule

`default_nettype wire

// File: source/strand_pc_file.sv
/*
 * Per-strand program counters
 * Advance on issue, redirected by faults and rollbacks
 */
`timescale 1ns/100ps
`default_nettype none

module strand_pc_file
	import strand_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Strand issued this cycle
	input wire issue_t issue,

	// Redirects from writeback
	input wire fault_t fault,
	input wire rollback_t rollback,

	// Handler address taken on a fault
	input wire logic [31:0] exception_handler,

	output logic [31:0] strand_pc [NUM_STRANDS]
);

	// One PC register per strand
	// On the same edge for the same strand a fault wins over a rollback
	// and a rollback wins over the issue advance
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
				strand_pc[s] <= '0;
		end
		else
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				if (fault.valid && fault.strand == strand_t'(s))
				begin
					// Handler address as it stood before this edge
					strand_pc[s] <= exception_handler;
				end
				else if (rollback.valid && rollback.strand == strand_t'(s))
				begin
					strand_pc[s] <= rollback.target;
				end
				else if (issue.valid && issue.strand == strand_t'(s))
				begin
					// Next sequential instruction
					strand_pc[s] <= strand_pc[s] + 32'd4;
				end
				// Stalled and disabled strands hold
			end
		end
	end

endmodule

`default_nettype wire

// File: source/issue_select.sv
/*
 * Round-robin issue selector
 * Picks the next ready strand after the last issued one
 */
`timescale 1ns/100ps
`default_nettype none

module issue_select
	import strand_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Enable mask from the control registers
	input wire logic [NUM_STRANDS - 1:0] strand_enable,

	// External stall level per strand
	input wire logic [NUM_STRANDS - 1:0] strand_stall,

	input wire logic [31:0] strand_pc [NUM_STRANDS],

	output issue_t issue
);

	// Last strand that issued
	strand_t last_strand;

	// Strands that may issue
	logic [NUM_STRANDS - 1:0] ready;

	// Search state
	strand_t candidate;
	logic found;

	assign ready = strand_enable & ~strand_stall;

	// Walk the strands starting after the last issued one
	// First ready strand wins
	always_comb
	begin
		issue = '0;
		found = 1'b0;
		for (int i = 1; i <= NUM_STRANDS; i++)
		begin
			// Wraps naturally at the strand count
			candidate = last_strand + strand_t'(i);
			if (!found && ready[candidate])
			begin
				found = 1'b1;
				issue.strand = candidate;
				issue.pc = strand_pc[candidate];
			end
		end
		// Nothing ready means no issue
		issue.valid = found;
	end

	// Pointer moves only when something issues
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			// Starts on the last strand so strand 0 goes first
			last_strand <= strand_t'(NUM_STRANDS - 1);
		end
		else if (issue.valid)
		begin
			last_strand <= issue.strand;
		end
	end

endmodule

`default_nettype wire

// File: source/strand_control.sv
/*
 * Strand control top level
 * Control registers, strand PC file and issue selector
 */
`timescale 1ns/100ps
`default_nettype none

module strand_control
	import strand_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Execute stage access
	input wire cr_access_t cr_access,

	// Writeback events
	input wire fault_t fault,
	input wire rollback_t rollback,

	// Per-strand stall level
	input wire logic [NUM_STRANDS - 1:0] strand_stall,

	output logic [31:0] cr_read_value,
	output logic [31:0] exception_handler,
	output logic [NUM_STRANDS - 1:0] strand_enable,
	output issue_t issue
);

	// PCs from the PC file to the selector
	logic [31:0] strand_pc [NUM_STRANDS];

	// Enable mask and handler address come from here
	control_registers i_control_registers
	(
		.clk(clk),
		.reset(reset),
		.access(cr_access),
		.fault(fault),
		.read_value(cr_read_value),
		.strand_enable(strand_enable),
		.exception_handler(exception_handler)
	);

	// PCs advance on issue and are redirected by faults and rollbacks
	strand_pc_file i_strand_pc_file
	(
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.fault(fault),
		.rollback(rollback),
		.exception_handler(exception_handler),
		.strand_pc(strand_pc)
	);

	// Chooses the issuing strand
	issue_select i_issue_select
	(
		.clk(clk),
		.reset(reset),
		.strand_enable(strand_enable),
		.strand_stall(strand_stall),
		.strand_pc(strand_pc),
		.issue(issue)
	);

endmodule

`default_nettype wire

// File: bench/strand_control_tb.sv
/*
 * Directed testbench for the strand control subsystem
 * Clock, reset, xorshift generator, reference model, one task per test
 */
`timescale 1ns/100ps
`default_nettype none

module strand_control_tb
	import strand_pkg::*;
();

	// Run limit in cycles with more than twice the test length as margin
	localparam int TIMEOUT_CYCLES = 400;

	logic clk;
	logic reset;
	cr_access_t cr_access;
	fault_t fault;
	rollback_t rollback;
	logic [NUM_STRANDS - 1:0] strand_stall;
	logic [31:0] cr_read_value;
	logic [31:0] exception_handler;
	logic [NUM_STRANDS - 1:0] strand_enable;
	issue_t issue;

	// Bench model of the architectural state
	logic [31:0] model_pc [NUM_STRANDS];
	strand_t model_last;
	logic [NUM_STRANDS - 1:0] model_enable;
	logic [31:0] model_handler;

	logic [31:0] rng_state;
	int cycle_count;
	int test_errors;
	int pass_count;
	int fail_count;

	strand_control i_strand_control
	(
		.clk(clk),
		.reset(reset),
		.cr_access(cr_access),
		.fault(fault),
		.rollback(rollback),
		.strand_stall(strand_stall),
		.cr_read_value(cr_read_value),
		.exception_handler(exception_handler),
		.strand_enable(strand_enable),
		.issue(issue)
	);

	always #50 clk = ~clk;

	// Cycle counter that ends a hung run
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Xorshift32 step
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	// One clock cycle with the inputs already driven
	// Checks the issue record, then advances the model at the rising edge
	task automatic step_cycle(input string name);
		logic [NUM_STRANDS - 1:0] ready;
		strand_t pick;
		logic found;
		found = 1'b0;
		pick = '0;
		#1;
		ready = model_enable & ~strand_stall;
		// Rotation starts after the last issued strand
		for (int k = 1; k <= NUM_STRANDS; k++)
		begin
			if (!found && ready[strand_t'(model_last + k)])
			begin
				found = 1'b1;
				pick = strand_t'(model_last + k);
			end
		end
		check_value({name, " issue valid"}, 32'(found), 32'(issue.valid));
		if (found)
		begin
			check_value({name, " issue strand"}, 32'(pick), 32'(issue.strand));
			check_value({name, " issue pc"}, model_pc[pick], issue.pc);
		end
		@(posedge clk);
		// Lowest priority first so fault overrides rollback overrides advance
		if (found)
		begin
			model_pc[pick] = model_pc[pick] + 32'd4;
			model_last = pick;
		end
		if (rollback.valid)
			model_pc[rollback.strand] = rollback.target;
		if (fault.valid)
			model_pc[fault.strand] = model_handler;
		if (cr_access.write_en)
		begin
			case (cr_access.index)
				CR_EXCEPTION_HANDLER: model_handler = cr_access.write_value;
				CR_STRAND_ENABLE: model_enable = cr_access.write_value[NUM_STRANDS - 1:0];
				CR_HALT_STRAND: model_enable[cr_access.strand] = 1'b0;
				CR_HALT: model_enable = '0;
			endcase
		end
		@(negedge clk);
		// Pulses last one cycle
		cr_access = '0;
		fault = '0;
		rollback = '0;
	endtask

	task automatic read_check(input string name, input strand_t strand,
		input logic [4:0] index, input logic [31:0] expected);
		cr_access.read_en = 1'b1;
		cr_access.strand = strand;
		cr_access.index = cr_index_t'(index);
		#1;
		check_value(name, expected, cr_read_value);
		step_cycle(name);
	endtask

	task automatic write_reg(input string name, input strand_t strand,
		input cr_index_t index, input logic [31:0] value);
		cr_access.write_en = 1'b1;
		cr_access.strand = strand;
		cr_access.index = index;
		cr_access.write_value = value;
		step_cycle(name);
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0)
		begin
			pass_count++;
			$display("%s: passed", name);
		end
		else
		begin
			fail_count++;
			$display("%s: %0d mismatches", name, test_errors);
		end
	endtask

	task automatic test_reset();
		test_errors = 0;
		check_value("reset enable", 32'h1, 32'(strand_enable));
		check_value("reset handler", 32'h0, exception_handler);
		// Core number is zero so the ID is the strand number
		for (int s = 0; s < NUM_STRANDS; s++)
			read_check("strand id", strand_t'(s), CR_STRAND_ID, 32'(s));
		report_test("reset state");
	endtask

	task automatic test_register();
		logic [31:0] handler;
		logic [31:0] mask;
		test_errors = 0;
		handler = next_random();
		mask = next_random();
		write_reg("handler write", 2'd0, CR_EXCEPTION_HANDLER, handler);
		check_value("handler output", handler, exception_handler);
		read_check("handler read", 2'd0, CR_EXCEPTION_HANDLER, handler);
		write_reg("enable write", 2'd0, CR_STRAND_ENABLE, mask);
		check_value("enable output", 32'(mask[3:0]), 32'(strand_enable));
		read_check("enable read", 2'd0, CR_STRAND_ENABLE, 32'(mask[3:0]));
		read_check("unused index 5", 2'd0, 5'd5, 32'h0);
		read_check("unused index 17", 2'd1, 5'd17, 32'h0);
		report_test("register access");
	endtask

	task automatic test_halts();
		test_errors = 0;
		write_reg("enable all", 2'd0, CR_STRAND_ENABLE, 32'hf);
		write_reg("halt strand 2", 2'd2, CR_HALT_STRAND, 32'h0);
		check_value("halt strand mask", 32'hb, 32'(strand_enable));
		write_reg("halt all", 2'd0, CR_HALT, 32'h0);
		check_value("halt all mask", 32'h0, 32'(strand_enable));
		step_cycle("halted issue");
		report_test("halts");
	endtask

	task automatic test_round_robin();
		logic [31:0] r;
		test_errors = 0;
		write_reg("enable all", 2'd0, CR_STRAND_ENABLE, 32'hf);
		repeat (32)
		begin
			r = next_random();
			strand_stall = r[3:0];
			step_cycle("round robin");
		end
		strand_stall = '0;
		report_test("round robin");
	endtask

	task automatic test_fault();
		logic [31:0] fault_pc;
		test_errors = 0;
		fault_pc = next_random();
		fault.valid = 1'b1;
		fault.strand = 2'd1;
		fault.pc = fault_pc;
		step_cycle("fault pulse");
		// Only strand 1 is ready and must restart at the handler
		strand_stall = 4'b1101;
		#1;
		check_value("fault redirect", model_handler, issue.pc);
		step_cycle("fault redirect");
		read_check("fault address", 2'd1, CR_FAULT_ADDRESS, fault_pc);
		// Fault and rollback together on strand 1
		fault.valid = 1'b1;
		fault.strand = 2'd1;
		fault.pc = next_random();
		rollback.valid = 1'b1;
		rollback.strand = 2'd1;
		rollback.target = next_random();
		strand_stall = '0;
		step_cycle("fault with rollback");
		strand_stall = 4'b1101;
		#1;
		check_value("fault over rollback", model_handler, issue.pc);
		step_cycle("fault over rollback");
		strand_stall = '0;
		report_test("fault");
	endtask

	task automatic test_rollback();
		logic [31:0] target;
		test_errors = 0;
		target = next_random();
		rollback.valid = 1'b1;
		rollback.strand = 2'd3;
		rollback.target = target;
		step_cycle("rollback pulse");
		strand_stall = 4'b0111;
		#1;
		check_value("rollback strand", 32'd3, 32'(issue.strand));
		check_value("rollback target", target, issue.pc);
		step_cycle("rollback issue");
		strand_stall = '0;
		report_test("rollback");
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		cr_access = '0;
		fault = '0;
		rollback = '0;
		strand_stall = '0;
		rng_state = 32'd57;
		cycle_count = 0;
		pass_count = 0;
		fail_count = 0;
		// Reset values of the model
		for (int s = 0; s < NUM_STRANDS; s++)
			model_pc[s] = '0;
		model_last = strand_t'(NUM_STRANDS - 1);
		model_enable = 4'b0001;
		model_handler = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset();
		test_register();
		test_halts();
		test_round_robin();
		test_fault();
		test_rollback();
		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
common/strand_pkg.sv
source/control_registers.sv
source/strand_pc_file.sv
source/issue_select.sv
source/strand_control.sv
bench/strand_control_tb.sv

// File: Bender.yml
package:
  name: strand_control

sources:
  - common/strand_pkg.sv
  - source/control_registers.sv
  - source/strand_pc_file.sv
  - source/issue_select.sv
  - source/strand_control.sv
  - target: test
    files:
      - bench/strand_control_tb.sv
